// ==== filelist.f ====
verilog/uart_tile_pkg.sv
verilog/noc2char.sv
verilog/char2noc.sv
verilog/char2uart.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_wb_slave.sv
verilog/uart_tile.sv
tests/tb_clkgen.sv
tests/tb_uart_tile.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the UART tile testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
   --top-module tb_uart_tile -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

./obj_dir/Vtb_uart_tile > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Done: no errors" sim.log; then
   exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== tests/tb_clkgen.sv ====
`timescale 1ns/10ps

module tb_clkgen #(
   parameter int PERIOD_NS = 40,
   parameter int RST_CYCLES = 3
) (
   output logic clk_o,
   output logic arst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;               // Free running
   end

   initial begin
      arst_n_o = 1'b0;                                       // Reset from time zero
      repeat (RST_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      arst_n_o = 1'b1;                                       // Released between edges
   end

endmodule

// ==== tests/tb_uart_tile.sv ====
`timescale 1ns/10ps

module tb_uart_tile;

   localparam int CPB = 8;                                   // Clocks per serial bit
   localparam int USE_VC = 1;
   localparam int TILE = 5;
   localparam int DEST = 9;
   localparam int CLS = 2;
   localparam int LIMIT = 40 * CPB;                          // Cycles allowed per wait

   logic        clk;
   logic        arst_n;
   logic [33:0] noc_in_flit;
   logic [33:0] noc_out_flit;
   logic [2:0]  noc_in_valid;
   logic [2:0]  noc_in_ready;
   logic [2:0]  noc_out_valid;
   logic [2:0]  noc_out_ready;
   logic        srx;
   logic        stx;
   logic [7:0]  chars [8];                                   // 0..3 tx, 4..6 rx, 7 dropped
   logic [7:0]  got;
   logic [31:0] rnd;
   logic [33:0] held_flit;
   logic [2:0]  held_valid;
   int          seed = 7128;

   tb_clkgen #(.PERIOD_NS(40), .RST_CYCLES(3)) tb_clkgen_i (.clk_o(clk), .arst_n_o(arst_n));

   uart_tile #(
      .USE_VCHANNEL(USE_VC), .TILE_ID(TILE), .DESTINATION(DEST), .PKT_CLASS(CLS),
      .CLKS_PER_BIT(CPB)
   ) uart_tile_i (
      .clk_i (clk), .arst_n_i (arst_n),
      .noc_in_flit_i (noc_in_flit), .noc_in_valid_i (noc_in_valid),
      .noc_in_ready_o (noc_in_ready), .noc_out_flit_o (noc_out_flit),
      .noc_out_valid_o (noc_out_valid), .noc_out_ready_i (noc_out_ready),
      .srx_i (srx), .stx_o (stx)
   );

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Done: errors found");
      $fatal(1, "Simulation stopped at first error");
   endtask

   task automatic check_eq(input string name, input logic [33:0] exp, input logic [33:0] act);
      assert (act === exp)
      else fail_run($sformatf("[ERROR] %0d ns: %s expected 0x%0h, got 0x%0h",
                              $time, name, exp, act));
   endtask

   // Type, dest, class, source, zero gap, char
   function automatic logic [33:0] make_flit(input logic [1:0] ftype, input logic [7:0] ch);
      return {ftype, 5'(DEST), 3'(CLS), 5'(TILE), 11'd0, ch};
   endfunction

   task automatic wait_reset_done();
      int t;
      t = 0;
      while (arst_n !== 1'b1) begin
         if (t >= LIMIT) fail_run("Timeout waiting for reset release");
         @(negedge clk);
         t++;
      end
      @(negedge clk);                                        // One active edge seen
   endtask

   task automatic send_flit(input logic [33:0] flit, input int ch);
      int t;
      t = 0;
      @(negedge clk);
      noc_in_flit = flit;
      noc_in_valid = 3'b000;
      noc_in_valid[ch] = 1'b1;
      while (noc_in_ready[ch] !== 1'b1) begin
         if (t >= LIMIT) fail_run("Timeout waiting for noc_in_ready_o");
         @(negedge clk);
         t++;
      end
      @(negedge clk);                                        // Taken at the edge before
      noc_in_valid = 3'b000;
   endtask

   task automatic drive_frame(input logic [7:0] ch);
      logic [9:0] bits;
      bits = {1'b1, ch, 1'b0};                               // Stop, data, start
      for (int b = 0; b < 10; b++) begin
         @(negedge clk);
         srx = bits[b];
         repeat (CPB - 1) @(negedge clk);
      end
   endtask

   // First low sample is half a cycle into the start bit
   task automatic receive_frame(output logic [7:0] data);
      logic [9:0]     bits;
      logic [CPB-1:0] win;                                   // All samples of one bit
      int             t;
      t = 0;
      @(negedge clk);
      while (stx !== 1'b0) begin
         if (t >= LIMIT) fail_run("Timeout waiting for start bit on stx_o");
         @(negedge clk);
         t++;
      end
      for (int b = 0; b < 10; b++) begin
         for (int c = 0; c < CPB; c++) begin
            if (b != 0 || c != 0) @(negedge clk);
            win[c] = stx;
         end
         bits[b] = win[CPB/2];                               // Mid-bit value
         check_eq("stx_o bit period", 34'({CPB{bits[b]}}), 34'(win));
      end
      check_eq("stx_o stop bit", 34'd1, 34'(bits[9]));
      data = bits[8:1];
   endtask

   task automatic wait_out_valid();
      int t;
      t = 0;
      while (noc_out_valid === 3'b000) begin
         if (t >= LIMIT) fail_run("Timeout waiting for noc_out_valid_o");
         @(negedge clk);
         t++;
      end
   endtask

   task automatic expect_out_flit(input logic [7:0] ch);
      wait_out_valid();
      check_eq("noc_out_valid_o", 34'(1 << USE_VC), 34'(noc_out_valid));
      check_eq("noc_out_flit_o", make_flit(2'b11, ch), noc_out_flit);
      @(negedge clk);                                        // Handshake edge passes
   endtask

   initial begin
      noc_in_flit = 34'd0;
      noc_in_valid = 3'b000;
      noc_out_ready = 3'b111;
      srx = 1'b1;                                            // Line idle
      for (int i = 0; i < 8; i++) begin
         rnd = $random(seed);
         chars[i] = rnd[7:0];
      end
      wait_reset_done();
      check_eq("noc_out_valid_o", 34'd0, 34'(noc_out_valid));
      check_eq("stx_o", 34'd1, 34'(stx));
      check_eq("noc_in_ready_o", 34'd7, 34'(noc_in_ready));
      fork                                                   // Flits in, frames out
         begin
            for (int i = 0; i < 4; i++) send_flit(make_flit(2'b11, chars[i]), 0);
         end
         begin
            for (int i = 0; i < 4; i++) begin
               receive_frame(got);
               check_eq("stx_o data", 34'(chars[i]), 34'(got));
            end
         end
      join
      send_flit(make_flit(2'b01, chars[7]), 0);              // Non-single type is dropped
      repeat (30 * CPB) begin
         @(negedge clk);
         check_eq("stx_o", 34'd1, 34'(stx));
      end
      check_eq("noc_in_ready_o", 34'd7, 34'(noc_in_ready));
      for (int i = 4; i < 6; i++) begin
         fork
            drive_frame(chars[i]);
            expect_out_flit(chars[i]);
         join
      end
      noc_out_ready = 3'b000;                                // Back-pressure
      fork
         drive_frame(chars[6]);
         expect_out_flit(chars[6]);
      join
      held_flit = noc_out_flit;
      held_valid = noc_out_valid;
      repeat (50) begin
         @(negedge clk);
         check_eq("noc_out_flit_o held", held_flit, noc_out_flit);
         check_eq("noc_out_valid_o held", 34'(held_valid), 34'(noc_out_valid));
      end
      noc_out_ready = 3'b111;
      @(negedge clk);                                        // Transfer at the edge before
      check_eq("noc_out_valid_o", 34'd0, 34'(noc_out_valid));
      $display("Done: no errors");
      $finish;
   end

endmodule

// ==== verilog/char2noc.sv ====
`timescale 1ns/10ps

module char2noc #(
   parameter int TILE_ID = 0,
   parameter int DESTINATION = 0,
   parameter int PKT_CLASS = 0
) (
   input  logic                                    clk_i,
   input  logic                                    arst_n_i,
   input  logic [7:0]                              char_data_i,
   input  logic                                    char_valid_i,
   output logic                                    char_ready_o,
   output logic [uart_tile_pkg::NOC_FLIT_WIDTH-1:0] noc_flit_o,
   output logic                                    noc_valid_o,
   input  logic                                    noc_ready_i
);

   logic [uart_tile_pkg::NOC_FLIT_WIDTH-1:0] flit_d;  // Assembled packet
   logic [uart_tile_pkg::NOC_FLIT_WIDTH-1:0] flit_q;
   logic                                    valid_q;
   logic                                    char_take;

   assign char_ready_o = ~valid_q;                           // One entry only
   assign char_take = char_valid_i & char_ready_o;

   // Header from parameters with zero gap bits
   always_comb begin
      flit_d = '0;
      flit_d[uart_tile_pkg::TYPE_MSB -: uart_tile_pkg::NOC_TYPE_WIDTH] =
         uart_tile_pkg::FLIT_TYPE_SINGLE;
      flit_d[uart_tile_pkg::DEST_MSB -: uart_tile_pkg::PH_DEST_WIDTH] =
         DESTINATION[uart_tile_pkg::PH_DEST_WIDTH-1:0];
      flit_d[uart_tile_pkg::CLS_MSB -: uart_tile_pkg::PH_CLS_WIDTH] =
         PKT_CLASS[uart_tile_pkg::PH_CLS_WIDTH-1:0];
      flit_d[uart_tile_pkg::SRC_MSB -: uart_tile_pkg::PH_SRC_WIDTH] =
         TILE_ID[uart_tile_pkg::PH_SRC_WIDTH-1:0];           // Own id as source
      flit_d[7:0] = char_data_i;
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         valid_q <= 1'b0;
      end else if (char_take) begin
         valid_q <= 1'b1;
      end else if (noc_ready_i) begin
         valid_q <= 1'b0;                                    // Flit left on the link
      end
   end

   always_ff @(posedge clk_i) begin
      if (char_take) begin
         flit_q <= flit_d;                                   // Held under back-pressure
      end
   end

   assign noc_flit_o = flit_q;
   assign noc_valid_o = valid_q;

endmodule

// ==== verilog/char2uart.sv ====
`timescale 1ns/10ps

module char2uart (
   input  logic                                     clk_i,
   input  logic                                     arst_n_i,
   input  logic [7:0]                               in_char_data_i,
   input  logic                                     in_char_valid_i,
   output logic                                     in_char_ready_o,
   output logic [7:0]                               out_char_data_o,
   output logic                                     out_char_valid_o,
   input  logic                                     out_char_ready_i,
   output logic                                     wb_cyc_o,
   output logic                                     wb_stb_o,
   output logic                                     wb_we_o,
   output logic [uart_tile_pkg::UART_ADDR_WIDTH-1:0] wb_adr_o,
   output logic [uart_tile_pkg::UART_DATA_WIDTH-1:0] wb_dat_o,
   input  logic                                     wb_ack_i,
   input  logic [uart_tile_pkg::UART_DATA_WIDTH-1:0] wb_dat_i
);

   typedef enum logic [1:0] {
      ST_POLL,   // Status read
      ST_READ,   // Rx data read
      ST_WRITE,  // Tx data write
      ST_HOLD    // Rx byte offered on out_char
   } state_t;

   state_t     state_q;
   logic       req_q;       // Bus cycle in flight
   logic [7:0] out_data_q;

   // Bus request held stable until ack
   assign wb_cyc_o = req_q;
   assign wb_stb_o = req_q;
   assign wb_we_o = (state_q == ST_WRITE);
   assign wb_adr_o = (state_q == ST_POLL) ? uart_tile_pkg::REG_STATUS : uart_tile_pkg::REG_DATA;
   assign wb_dat_o = in_char_data_i;                         // noc2char holds it until ready

   assign in_char_ready_o = req_q & wb_ack_i & (state_q == ST_WRITE); // Byte taken by UART
   assign out_char_valid_o = (state_q == ST_HOLD);
   assign out_char_data_o = out_data_q;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= ST_POLL;
         req_q <= 1'b0;
      end else if (!req_q) begin
         if (state_q != ST_HOLD) begin
            req_q <= 1'b1;                                   // Start next access
         end else if (out_char_ready_i) begin
            state_q <= ST_POLL;                              // Byte handed to char2noc
         end
      end else if (wb_ack_i) begin
         req_q <= 1'b0;                                      // Drop after ack
         case (state_q)
            ST_POLL: begin
               // Rx first so the receiver is drained early
               if (wb_dat_i[uart_tile_pkg::STAT_RX_VALID] && out_char_ready_i) begin
                  state_q <= ST_READ;
               end else if (in_char_valid_i && !wb_dat_i[uart_tile_pkg::STAT_TX_BUSY]) begin
                  state_q <= ST_WRITE;
               end
            end
            ST_READ: state_q <= ST_HOLD;
            default: state_q <= ST_POLL;                     // Write done
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (req_q && wb_ack_i && state_q == ST_READ) begin
         out_data_q <= wb_dat_i;                             // Capture rx byte
      end
   end

endmodule

// ==== verilog/noc2char.sv ====
`timescale 1ns/10ps

module noc2char (
   input  logic                                    clk_i,
   input  logic                                    arst_n_i,
   input  logic [uart_tile_pkg::NOC_FLIT_WIDTH-1:0] noc_flit_i,
   input  logic                                    noc_valid_i,
   output logic                                    noc_ready_o,
   output logic [7:0]                              char_data_o,
   output logic                                    char_valid_o,
   input  logic                                    char_ready_i
);

   logic       char_valid_q;  // Entry occupied
   logic [7:0] char_data_q;
   logic       flit_take;     // Flit handshake
   logic       is_single;

   assign noc_ready_o = ~char_valid_q;                       // Accept only when empty
   assign flit_take = noc_valid_i & noc_ready_o;
   assign is_single = (noc_flit_i[uart_tile_pkg::TYPE_MSB -: uart_tile_pkg::NOC_TYPE_WIDTH]
                       == uart_tile_pkg::FLIT_TYPE_SINGLE);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         char_valid_q <= 1'b0;
      end else if (flit_take) begin
         char_valid_q <= is_single;                          // Other types consumed, dropped
      end else if (char_valid_q && char_ready_i) begin
         char_valid_q <= 1'b0;                               // Char handed on
      end
   end

   always_ff @(posedge clk_i) begin
      if (flit_take && is_single) begin
         char_data_q <= noc_flit_i[7:0];                     // Char in low byte
      end
   end

   assign char_data_o = char_data_q;
   assign char_valid_o = char_valid_q;

endmodule

// ==== verilog/uart_rx.sv ====
`timescale 1ns/10ps

module uart_rx #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic       clk_i,
   input  logic       arst_n_i,
   input  logic       srx_i,
   output logic [7:0] rx_data_o,
   output logic       rx_strobe_o
);

   localparam int CW = $clog2(CLKS_PER_BIT + 1);
   localparam int HALF = CLKS_PER_BIT / 2;

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} state_t;

   state_t        state_q;
   logic [1:0]    sync_q;     // Two-flop synchronizer
   logic          rx_bit;
   logic [CW-1:0] clk_cnt_q;
   logic [2:0]    bit_cnt_q;
   logic [7:0]    shift_q;
   logic          bit_end;

   assign rx_bit = sync_q[1];
   assign bit_end = (clk_cnt_q == CW'(CLKS_PER_BIT - 1));

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         sync_q <= 2'b11;
         state_q <= RX_IDLE;
         clk_cnt_q <= '0;
         bit_cnt_q <= '0;
         rx_strobe_o <= 1'b0;
      end else begin
         sync_q <= {sync_q[0], srx_i};
         rx_strobe_o <= 1'b0;
         clk_cnt_q <= clk_cnt_q + 1'b1;
         case (state_q)
            RX_IDLE: begin
               clk_cnt_q <= '0;
               if (!rx_bit) state_q <= RX_START;             // Falling start edge
            end
            RX_START: if (clk_cnt_q == CW'(HALF - 1)) begin
               clk_cnt_q <= '0;
               bit_cnt_q <= '0;
               state_q <= rx_bit ? RX_IDLE : RX_DATA;        // Glitch, not a start
            end
            RX_DATA: if (bit_end) begin
               clk_cnt_q <= '0;
               bit_cnt_q <= bit_cnt_q + 3'd1;
               if (bit_cnt_q == 3'd7) state_q <= RX_STOP;
            end
            default: if (bit_end) begin
               state_q <= RX_IDLE;
               rx_strobe_o <= rx_bit;                        // No strobe on a framing error
            end
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == RX_DATA && bit_end) begin
         shift_q <= {rx_bit, shift_q[7:1]};                  // LSB first
      end
   end

   assign rx_data_o = shift_q;

endmodule

// ==== verilog/uart_tile.sv ====
`timescale 1ns/10ps

module uart_tile #(
   parameter int VCHANNELS = 3,
   parameter int USE_VCHANNEL = 0,
   parameter int TILE_ID = 0,
   parameter int DESTINATION = 0,
   parameter int PKT_CLASS = 0,
   parameter int CLKS_PER_BIT = 16
) (
   input  logic                                    clk_i,
   input  logic                                    arst_n_i,
   input  logic [uart_tile_pkg::NOC_FLIT_WIDTH-1:0] noc_in_flit_i,
   input  logic [VCHANNELS-1:0]                    noc_in_valid_i,
   output logic [VCHANNELS-1:0]                    noc_in_ready_o,
   output logic [uart_tile_pkg::NOC_FLIT_WIDTH-1:0] noc_out_flit_o,
   output logic [VCHANNELS-1:0]                    noc_out_valid_o,
   input  logic [VCHANNELS-1:0]                    noc_out_ready_i,
   input  logic                                    srx_i,
   output logic                                    stx_o
);

   logic                                     in_ready, out_valid;
   logic [7:0]                               in_char_data, out_char_data;
   logic                                     in_char_valid, in_char_ready;
   logic                                     out_char_valid, out_char_ready;
   logic                                     wb_cyc, wb_stb, wb_we, wb_ack;
   logic [uart_tile_pkg::UART_ADDR_WIDTH-1:0] wb_adr;
   logic [uart_tile_pkg::UART_DATA_WIDTH-1:0] wb_dat_w, wb_dat_r;

   assign noc_in_ready_o = {VCHANNELS{in_ready}};           // Same ready on every channel

   always_comb begin
      noc_out_valid_o = '0;
      noc_out_valid_o[USE_VCHANNEL] = out_valid;             // Only our channel
   end

   noc2char noc2char_i (
      .clk_i (clk_i), .arst_n_i (arst_n_i),
      .noc_flit_i (noc_in_flit_i), .noc_valid_i (|noc_in_valid_i), .noc_ready_o (in_ready),
      .char_data_o (in_char_data), .char_valid_o (in_char_valid), .char_ready_i (in_char_ready)
   );

   char2uart char2uart_i (
      .clk_i (clk_i), .arst_n_i (arst_n_i),
      .in_char_data_i (in_char_data), .in_char_valid_i (in_char_valid),
      .in_char_ready_o (in_char_ready), .out_char_data_o (out_char_data),
      .out_char_valid_o (out_char_valid), .out_char_ready_i (out_char_ready),
      .wb_cyc_o (wb_cyc), .wb_stb_o (wb_stb), .wb_we_o (wb_we), .wb_adr_o (wb_adr),
      .wb_dat_o (wb_dat_w), .wb_ack_i (wb_ack), .wb_dat_i (wb_dat_r)
   );

   char2noc #(.TILE_ID(TILE_ID), .DESTINATION(DESTINATION), .PKT_CLASS(PKT_CLASS)) char2noc_i (
      .clk_i (clk_i), .arst_n_i (arst_n_i),
      .char_data_i (out_char_data), .char_valid_i (out_char_valid),
      .char_ready_o (out_char_ready), .noc_flit_o (noc_out_flit_o),
      .noc_valid_o (out_valid), .noc_ready_i (noc_out_ready_i[USE_VCHANNEL])
   );

   uart_wb_slave #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_wb_slave_i (
      .clk_i (clk_i), .arst_n_i (arst_n_i),
      .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we), .wb_adr_i (wb_adr),
      .wb_dat_i (wb_dat_w), .wb_ack_o (wb_ack), .wb_dat_o (wb_dat_r),
      .srx_i (srx_i), .stx_o (stx_o)
   );

endmodule

// ==== verilog/uart_tile_pkg.sv ====
package uart_tile_pkg;

   // Flit layout
   localparam int NOC_DATA_WIDTH = 32;                       // Payload bits
   localparam int NOC_TYPE_WIDTH = 2;                        // Head/tail flags
   localparam int NOC_FLIT_WIDTH = NOC_DATA_WIDTH + NOC_TYPE_WIDTH;

   localparam logic [NOC_TYPE_WIDTH-1:0] FLIT_TYPE_SINGLE = 2'b11; // Head and tail at once

   // Packet header fields
   localparam int PH_DEST_WIDTH = 5;
   localparam int PH_CLS_WIDTH = 3;
   localparam int PH_SRC_WIDTH = 5;

   localparam int TYPE_MSB = NOC_FLIT_WIDTH - 1;             // Bits 33:32
   localparam int DEST_MSB = NOC_DATA_WIDTH - 1;             // Bits 31:27
   localparam int CLS_MSB = DEST_MSB - PH_DEST_WIDTH;        // Bits 26:24
   localparam int SRC_MSB = CLS_MSB - PH_CLS_WIDTH;          // Bits 23:19

   // UART register map
   localparam int UART_ADDR_WIDTH = 3;
   localparam int UART_DATA_WIDTH = 8;

   localparam logic [UART_ADDR_WIDTH-1:0] REG_DATA = 3'd0;   // Wr sends, rd pops rx byte
   localparam logic [UART_ADDR_WIDTH-1:0] REG_STATUS = 3'd1; // Read only
   localparam int STAT_TX_BUSY = 0;                          // Frame on the line
   localparam int STAT_RX_VALID = 1;                         // Unread rx byte

endpackage

// ==== verilog/uart_tx.sv ====
`timescale 1ns/10ps

module uart_tx #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic       clk_i,
   input  logic       arst_n_i,
   input  logic       tx_start_i,
   input  logic [7:0] tx_data_i,
   output logic       tx_busy_o,
   output logic       stx_o
);

   localparam int CW = $clog2(CLKS_PER_BIT + 1);

   logic [CW-1:0] clk_cnt_q;  // Divider within a bit
   logic [3:0]    bit_cnt_q;  // 0 start, 1..8 data, 9 stop
   logic [9:0]    shift_q;    // LSB is on the line
   logic          busy_q;
   logic          bit_end;

   assign bit_end = (clk_cnt_q == CW'(CLKS_PER_BIT - 1));

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         busy_q <= 1'b0;
         clk_cnt_q <= '0;
         bit_cnt_q <= '0;
         shift_q <= '1;                                      // Idle high
      end else if (!busy_q) begin
         if (tx_start_i) begin
            busy_q <= 1'b1;
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
            shift_q <= {1'b1, tx_data_i, 1'b0};             // Stop, data, start
         end
      end else if (bit_end) begin
         clk_cnt_q <= '0;
         shift_q <= {1'b1, shift_q[9:1]};                   // Next bit, fill with idle
         bit_cnt_q <= bit_cnt_q + 4'd1;
         if (bit_cnt_q == 4'd9) begin
            busy_q <= 1'b0;                                  // End of stop bit
         end
      end else begin
         clk_cnt_q <= clk_cnt_q + 1'b1;
      end
   end

   assign tx_busy_o = busy_q;
   assign stx_o = shift_q[0];

endmodule

// ==== verilog/uart_wb_slave.sv ====
`timescale 1ns/10ps

module uart_wb_slave #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic                                     clk_i,
   input  logic                                     arst_n_i,
   input  logic                                     wb_cyc_i,
   input  logic                                     wb_stb_i,
   input  logic                                     wb_we_i,
   input  logic [uart_tile_pkg::UART_ADDR_WIDTH-1:0] wb_adr_i,
   input  logic [uart_tile_pkg::UART_DATA_WIDTH-1:0] wb_dat_i,
   output logic                                     wb_ack_o,
   output logic [uart_tile_pkg::UART_DATA_WIDTH-1:0] wb_dat_o,
   input  logic                                     srx_i,
   output logic                                     stx_o
);

   logic                                     ack_q;
   logic [uart_tile_pkg::UART_DATA_WIDTH-1:0] dat_q;
   logic [uart_tile_pkg::UART_DATA_WIDTH-1:0] status;
   logic                                     access;      // First cycle of a bus cycle
   logic                                     data_sel;
   logic                                     tx_start;
   logic                                     tx_busy;
   logic [7:0]                               rx_data;
   logic                                     rx_strobe;
   logic [7:0]                               rx_byte_q;
   logic                                     rx_valid_q;

   assign access = wb_cyc_i & wb_stb_i & ~ack_q;
   assign data_sel = (wb_adr_i == uart_tile_pkg::REG_DATA);
   assign tx_start = access & wb_we_i & data_sel;           // Data write sends

   always_comb begin
      status = '0;
      status[uart_tile_pkg::STAT_TX_BUSY] = tx_busy;
      status[uart_tile_pkg::STAT_RX_VALID] = rx_valid_q;
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q <= 1'b0;
         rx_valid_q <= 1'b0;
      end else begin
         ack_q <= access;                                    // One-cycle ack pulse
         if (rx_strobe) begin
            rx_valid_q <= 1'b1;                              // New byte wins over pop
         end else if (access && !wb_we_i && data_sel) begin
            rx_valid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (rx_strobe) rx_byte_q <= rx_data;                   // Overwrites unread byte
      if (access) dat_q <= data_sel ? rx_byte_q : status;
   end

   assign wb_ack_o = ack_q;
   assign wb_dat_o = dat_q;

   uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_tx_i (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .tx_start_i (tx_start),
      .tx_data_i  (wb_dat_i),
      .tx_busy_o  (tx_busy),
      .stx_o      (stx_o)
   );

   uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_rx_i (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .srx_i       (srx_i),
      .rx_data_o   (rx_data),
      .rx_strobe_o (rx_strobe)
   );

endmodule
